// File: src/band_mask_pkg.sv
package band_mask_pkg;

  //////////////////////////////////////////////////
  // Word and lane geometry
  //////////////////////////////////////////////////

  // Input word width
  localparam int DATA_W = 128;

  // Real lanes per word, the finest lane split
  localparam int NUM_LANES = 8;
  localparam int LANE_W    = DATA_W / NUM_LANES;

  // Complex and wide lanes cover two and four real lanes
  localparam int CPLX_LANES = NUM_LANES / 2;
  localparam int WIDE_LANES = NUM_LANES / 4;

  // Word index within a frame, wraps at 8 bits
  localparam int WORD_IDX_W = 8;

  // Bin number is word index times 8 plus real lane
  localparam int BIN_W = WORD_IDX_W + $clog2(NUM_LANES);

  //////////////////////////////////////////////////
  // Formats and flags
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FMT_REAL    = 2'd0,
    FMT_COMPLEX = 2'd1,
    FMT_WIDE    = 2'd2
  } lane_fmt_e;

  // One hit bit per lane, for all three formats at once
  typedef struct packed {
    logic [NUM_LANES-1:0]  real_hit;
    logic [CPLX_LANES-1:0] cplx_hit;
    logic [WIDE_LANES-1:0] wide_hit;
  } edge_flags_t;

  //////////////////////////////////////////////////
  // Pipeline depths
  //////////////////////////////////////////////////

  // Low edge takes the longer path
  localparam int LF_STAGES = 2;
  localparam int HF_STAGES = 1;

  // Tracker, low-edge compare, then the combiner register
  localparam int MASK_LATENCY = 1 + LF_STAGES + 1;

endpackage

// File: src/align_delay.sv
module align_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t i_din,
  output payload_t o_dout
);

  // Stage 0 takes the input, the last stage drives the output
  payload_t stage [DEPTH];

  //////////////////////////////////////////////////
  // Shift chain
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= payload_t'(0);
      end
    end else begin
      stage[0] <= i_din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign o_dout = stage[DEPTH-1];

endmodule

// File: src/frame_bin_tracker.sv
module frame_bin_tracker
  import band_mask_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_valid,
  input  logic                  i_frame_start,
  input  logic [DATA_W-1:0]     i_data,
  output logic                  o_valid,
  output logic [DATA_W-1:0]     o_data,
  output logic [WORD_IDX_W-1:0] o_word_idx
);

  // Index that the next non-start word will take
  logic [WORD_IDX_W-1:0] word_cnt;

  //////////////////////////////////////////////////
  // Word counter and strobe
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt   <= '0;
      o_word_idx <= '0;
      o_valid    <= 1'b0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        if (i_frame_start) begin
          // First word of a frame is bin group 0
          o_word_idx <= '0;
          word_cnt   <= WORD_IDX_W'(1);
        end else begin
          o_word_idx <= word_cnt;
          word_cnt   <= word_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Data register
  //////////////////////////////////////////////////

  // Loaded only with a valid word
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

// File: src/band_edge_compare.sv
module band_edge_compare
  import band_mask_pkg::*;
#(
  parameter bit UPPER_EDGE = 1'b0,
  parameter int STAGES     = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [WORD_IDX_W-1:0] i_word_idx,
  input  logic [BIN_W-1:0]      i_bound,
  output edge_flags_t           o_flags
);

  edge_flags_t hit_d;
  edge_flags_t hit_q;

  // Upper edge keeps bins at or below the bound, lower edge at or above
  function automatic logic edge_hit(input logic [BIN_W-1:0] bin,
                                    input logic [BIN_W-1:0] bound);
    if (UPPER_EDGE) begin
      return bin <= bound;
    end
    return bin >= bound;
  endfunction

  //////////////////////////////////////////////////
  // Lane bins for each format
  //////////////////////////////////////////////////

  always_comb begin
    logic [BIN_W-1:0] bin;
    hit_d = '0;
    // Real: idx*8 + lane
    for (int l = 0; l < NUM_LANES; l++) begin
      bin = {i_word_idx, 3'(l)};
      hit_d.real_hit[l] = edge_hit(bin, i_bound);
    end
    // Complex: idx*4 + lane
    for (int l = 0; l < CPLX_LANES; l++) begin
      bin = {1'b0, i_word_idx, 2'(l)};
      hit_d.cplx_hit[l] = edge_hit(bin, i_bound);
    end
    // Wide: idx*2 + lane
    for (int l = 0; l < WIDE_LANES; l++) begin
      bin = {2'b0, i_word_idx, 1'(l)};
      hit_d.wide_hit[l] = edge_hit(bin, i_bound);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_q <= '0;
    end else begin
      hit_q <= hit_d;
    end
  end

  //////////////////////////////////////////////////
  // Extra stages
  //////////////////////////////////////////////////

  if (STAGES > 1) begin : g_retime
    align_delay #(
      .payload_t (edge_flags_t),
      .DEPTH     (STAGES - 1)
    ) u_flag_delay (
      .clk    (clk),
      .rst_n  (rst_n),
      .i_din  (hit_q),
      .o_dout (o_flags)
    );
  end else begin : g_single
    assign o_flags = hit_q;
  end

endmodule

// File: src/band_combine.sv
module band_combine
  import band_mask_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_valid,
  input  logic [DATA_W-1:0] i_data,
  input  lane_fmt_e         i_fmt,
  input  edge_flags_t       i_lf_flags,
  input  edge_flags_t       i_hf_flags,
  output logic              o_valid,
  output logic [DATA_W-1:0] o_data
);

  // Lanes inside both edges
  logic [NUM_LANES-1:0]  real_in_band;
  logic [CPLX_LANES-1:0] cplx_in_band;
  logic [WIDE_LANES-1:0] wide_in_band;

  // Keep bit per 16-bit slice, whatever the format
  logic [NUM_LANES-1:0] lane_keep;
  logic [DATA_W-1:0]    masked_data;

  //////////////////////////////////////////////////
  // Flag combination
  //////////////////////////////////////////////////

  assign real_in_band = i_lf_flags.real_hit & i_hf_flags.real_hit;
  assign cplx_in_band = i_lf_flags.cplx_hit & i_hf_flags.cplx_hit;
  assign wide_in_band = i_lf_flags.wide_hit & i_hf_flags.wide_hit;

  // Spread each complex or wide flag over the real slices it covers
  always_comb begin
    lane_keep = '0;
    case (i_fmt)
      FMT_REAL: begin
        lane_keep = real_in_band;
      end
      FMT_COMPLEX: begin
        for (int l = 0; l < NUM_LANES; l++) begin
          lane_keep[l] = cplx_in_band[l / (NUM_LANES / CPLX_LANES)];
        end
      end
      FMT_WIDE: begin
        for (int l = 0; l < NUM_LANES; l++) begin
          lane_keep[l] = wide_in_band[l / (NUM_LANES / WIDE_LANES)];
        end
      end
      default: begin
        lane_keep = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Lane masking
  //////////////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      masked_data[l*LANE_W +: LANE_W] = lane_keep[l] ? i_data[l*LANE_W +: LANE_W]
                                                     : '0;
    end
  end

  // Output holds its last word between strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
      o_data  <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_data <= masked_data;
      end
    end
  end

endmodule

// File: src/band_mask_top.sv
module band_mask_top
  import band_mask_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_valid,
  input  logic              i_frame_start,
  input  logic [DATA_W-1:0] i_data,
  input  lane_fmt_e         i_fmt,
  input  logic [BIN_W-1:0]  i_lf_bound,
  input  logic [BIN_W-1:0]  i_hf_bound,
  output logic              o_valid,
  output logic [DATA_W-1:0] o_data
);

  // Tracker outputs
  logic                  trk_valid;
  logic [DATA_W-1:0]     trk_data;
  logic [WORD_IDX_W-1:0] trk_word_idx;

  // Edge flags straight from the comparators
  edge_flags_t lf_flags;
  edge_flags_t hf_flags;

  // Everything aligned to the low-edge flags
  edge_flags_t       hf_flags_al;
  logic              valid_al;
  logic [DATA_W-1:0] data_al;
  lane_fmt_e         fmt_al;

  //////////////////////////////////////////////////
  // Front end
  //////////////////////////////////////////////////

  frame_bin_tracker u_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (i_valid),
    .i_frame_start (i_frame_start),
    .i_data        (i_data),
    .o_valid       (trk_valid),
    .o_data        (trk_data),
    .o_word_idx    (trk_word_idx)
  );

  band_edge_compare #(.UPPER_EDGE(1'b0), .STAGES(LF_STAGES)) u_lf_compare (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_word_idx (trk_word_idx),
    .i_bound    (i_lf_bound),
    .o_flags    (lf_flags)
  );

  band_edge_compare #(.UPPER_EDGE(1'b1), .STAGES(HF_STAGES)) u_hf_compare (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_word_idx (trk_word_idx),
    .i_bound    (i_hf_bound),
    .o_flags    (hf_flags)
  );

  //////////////////////////////////////////////////
  // Alignment
  //////////////////////////////////////////////////

  align_delay #(.payload_t(edge_flags_t), .DEPTH(LF_STAGES - HF_STAGES)) u_hf_align (
    .clk (clk), .rst_n (rst_n), .i_din (hf_flags), .o_dout (hf_flags_al)
  );

  align_delay #(.payload_t(logic [DATA_W-1:0]), .DEPTH(LF_STAGES)) u_data_align (
    .clk (clk), .rst_n (rst_n), .i_din (trk_data), .o_dout (data_al)
  );

  align_delay #(.payload_t(logic), .DEPTH(LF_STAGES)) u_valid_align (
    .clk (clk), .rst_n (rst_n), .i_din (trk_valid), .o_dout (valid_al)
  );

  // Format comes straight from the port, so it also covers the tracker stage
  align_delay #(.payload_t(lane_fmt_e), .DEPTH(LF_STAGES + 1)) u_fmt_align (
    .clk (clk), .rst_n (rst_n), .i_din (i_fmt), .o_dout (fmt_al)
  );

  band_combine u_combine (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_valid    (valid_al),
    .i_data     (data_al),
    .i_fmt      (fmt_al),
    .i_lf_flags (lf_flags),
    .i_hf_flags (hf_flags_al),
    .o_valid    (o_valid),
    .o_data     (o_data)
  );

endmodule

// File: verification/band_mask_assertions.sv
module band_mask_assertions
  import band_mask_pkg::*;
#(
  parameter int LATENCY       = MASK_LATENCY,
  parameter bit CHECK_LATENCY = 1'b1
) (
  input logic              clk,
  input logic              rst_n,
  input logic              i_valid,
  input logic              o_valid,
  input logic [DATA_W-1:0] o_data
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // Strobe timing
  //////////////////////////////////////////////////

  if (CHECK_LATENCY) begin : g_latency
    // One output strobe per input strobe, a fixed number of clocks later
    a_strobe_latency: assert property (
      @(posedge clk) disable iff (!rst_n) o_valid == $past(i_valid, LATENCY)
    ) else $error("output strobe is not the input strobe delayed by %0d cycles", LATENCY);
  end

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  a_valid_low_in_reset: assert property (
    @(posedge clk) !rst_n |-> !o_valid
  ) else $error("output strobe high while reset is active");

  // First clock out of reset
  a_valid_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |=> !o_valid
  ) else $error("output strobe high on the first cycle after reset");

  a_data_zero_in_reset: assert property (
    @(posedge clk) !rst_n |-> o_data == '0
  ) else $error("output data not cleared while reset is active");

endmodule

bind band_mask_top band_mask_assertions #(
  .LATENCY (band_mask_pkg::MASK_LATENCY)
) u_top_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .i_valid (i_valid),
  .o_valid (o_valid),
  .o_data  (o_data)
);

bind band_combine band_mask_assertions #(
  .CHECK_LATENCY (1'b0)
) u_combine_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .i_valid (i_valid),
  .o_valid (o_valid),
  .o_data  (o_data)
);

// File: verification/band_mask_tb.sv
module band_mask_tb
  import band_mask_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Output strobe trails the input strobe by this many clocks
  localparam int LATENCY   = 4;
  localparam int MAX_FRAME = 40;
  localparam int BIN_MAX   = (1 << BIN_W) - 1;
  // Frames over all tests, with some spare
  localparam int FRAME_BUDGET = 32;
  localparam int MAX_CYCLES   = FRAME_BUDGET * (MAX_FRAME * 4 + 20) + 100;

  logic              clk;
  logic              rst_n;
  logic              i_valid;
  logic              i_frame_start;
  logic [DATA_W-1:0] i_data;
  lane_fmt_e         i_fmt;
  logic [BIN_W-1:0]  i_lf_bound;
  logic [BIN_W-1:0]  i_hf_bound;
  logic              o_valid;
  logic [DATA_W-1:0] o_data;

  logic [31:0]       lfsr_state;
  logic [DATA_W-1:0] exp_data_q[$];
  int                exp_cyc_q[$];
  int                cycle_cnt = 0;
  int                next_idx = 0;
  int                err_cnt = 0;
  int                check_cnt = 0;
  int                tests_run = 0;
  int                test_err_base = 0;
  lane_fmt_e         cur_fmt;
  int                cur_lf;
  int                cur_hf;

  band_mask_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (i_valid),
    .i_frame_start (i_frame_start),
    .i_data        (i_data),
    .i_fmt         (i_fmt),
    .i_lf_bound    (i_lf_bound),
    .i_hf_bound    (i_hf_bound),
    .o_valid       (o_valid),
    .o_data        (o_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin : watchdog
    for (int c = 0; c < MAX_CYCLES; c++) begin
      @(posedge clk);
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic int rand_range(input int n);
    return int'(rand_bits(16)) % n;
  endfunction

  function automatic int lanes_of(input lane_fmt_e fmt);
    case (fmt)
      FMT_COMPLEX: return 4;
      FMT_WIDE:    return 2;
      default:     return 8;
    endcase
  endfunction

  // Lane l of word idx holds bin idx*lanes + l
  function automatic logic [DATA_W-1:0] model_mask(input logic [DATA_W-1:0] data,
                                                   input lane_fmt_e fmt, input int idx,
                                                   input int lf, input int hf);
    logic [DATA_W-1:0] r;
    int lanes;
    int w;
    int bin;
    r = '0;
    lanes = lanes_of(fmt);
    w = DATA_W / lanes;
    for (int l = 0; l < lanes; l++) begin
      bin = idx * lanes + l;
      if (bin >= lf && bin <= hf) begin
        for (int b = 0; b < w; b++) begin
          r[l*w+b] = data[l*w+b];
        end
      end
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_output();
    logic [DATA_W-1:0] exp_data;
    int exp_cyc;
    if (exp_data_q.size() == 0) begin
      err_cnt++;
      $display("Output strobe at %0t with no word in flight", $time);
    end else begin
      exp_data = exp_data_q.pop_front();
      exp_cyc = exp_cyc_q.pop_front();
      check_value("output word", o_data, exp_data);
      check_value("strobe cycle", DATA_W'(cycle_cnt), DATA_W'(exp_cyc));
    end
  endtask

  // Outputs are registered, so they are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n && o_valid) begin
      check_output();
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      i_valid = 1'b0;
      i_frame_start = 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_data_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  task automatic set_config(input lane_fmt_e fmt, input int lf, input int hf);
    drain();
    @(negedge clk);
    i_fmt = fmt;
    i_lf_bound = BIN_W'(lf);
    i_hf_bound = BIN_W'(hf);
    cur_fmt = fmt;
    cur_lf = lf;
    cur_hf = hf;
    idle(6);
  endtask

  task automatic send_word(input logic fs);
    logic [DATA_W-1:0] d;
    int idx;
    d = {rand_bits(64), rand_bits(64)};
    idx = fs ? 0 : next_idx;
    next_idx = (idx + 1) % 256;
    @(negedge clk);
    i_valid = 1'b1;
    i_frame_start = fs;
    i_data = d;
    exp_data_q.push_back(model_mask(d, cur_fmt, idx, cur_lf, cur_hf));
    exp_cyc_q.push_back(cycle_cnt + LATENCY);
  endtask

  // restart_at below zero means no restart inside the frame
  task automatic send_frame(input int len, input int gap_max, input int restart_at);
    for (int w = 0; w < len; w++) begin
      send_word(w == 0 || w == restart_at);
      if (gap_max > 0) begin
        idle(rand_range(gap_max + 1));
      end
    end
  endtask

  task automatic random_frames(input lane_fmt_e fmt, input int n_frames, input int gap_max);
    int span;
    int lf;
    int hf;
    span = lanes_of(fmt) * MAX_FRAME;
    for (int f = 0; f < n_frames; f++) begin
      lf = rand_range(span);
      hf = lf + rand_range(span);
      if (hf > BIN_MAX) begin
        hf = BIN_MAX;
      end
      set_config(fmt, lf, hf);
      send_frame(1 + rand_range(MAX_FRAME), gap_max, -1);
    end
  endtask

  task automatic end_test(input string name);
    drain();
    tests_run++;
    $display("Test %0d %s: done, %0d errors", tests_run, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    lfsr_state = 32'h50fa;
    rst_n = 1'b1;
    i_valid = 1'b0;
    i_frame_start = 1'b0;
    i_data = '0;
    i_fmt = FMT_REAL;
    i_lf_bound = '0;
    i_hf_bound = '0;
    cur_fmt = FMT_REAL;
    cur_lf = 0;
    cur_hf = 0;
    #2;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    random_frames(FMT_REAL, 5, 2);
    end_test("real lanes");
    random_frames(FMT_COMPLEX, 5, 2);
    end_test("complex lanes");
    random_frames(FMT_WIDE, 5, 2);
    end_test("wide lanes");

    // Empty band, then a band covering every bin
    for (int f = 0; f < 3; f++) begin
      set_config(lane_fmt_e'(f), 300, 100);
      send_frame(12, 1, -1);
      set_config(lane_fmt_e'(f), 0, BIN_MAX);
      send_frame(12, 1, -1);
    end
    end_test("edge bounds");

    set_config(FMT_REAL, 16, 60);
    send_frame(20, 1, 9);
    set_config(FMT_COMPLEX, 10, 30);
    send_frame(16, 0, 6);
    end_test("mid-frame restart");

    set_config(FMT_REAL, 40, 200);
    send_frame(32, 0, -1);
    send_frame(20, 0, -1);
    random_frames(FMT_WIDE, 2, 3);
    end_test("strobe spacing");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sources.f
src/band_mask_pkg.sv
src/align_delay.sv
src/frame_bin_tracker.sv
src/band_edge_compare.sv
src/band_combine.sv
src/band_mask_top.sv
verification/band_mask_assertions.sv
verification/band_mask_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= band_mask_tb
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
